/* hdl/edge_bank.sv */
`timescale 1ns/100ps

module edge_bank (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  logic                   tag_sos,
    input  logic                   tag_eos,
    input  edge_bank_pkg::dest_e   tag_dest,
    input  gnn_data_pkg::fv_t      tag_fv_0,
    input  gnn_data_pkg::fv_t      tag_fv_1,
    input  gnn_data_pkg::node_id_t tag_node_id,
    input  logic                   req_grant,
    input  logic                   rs_grant,
    input  logic                   rs_available,
    output logic                   bank_busy,
    output logic                   outbuff_req,
    output logic                   outbuff_sos,
    output logic                   outbuff_eos,
    output gnn_data_pkg::fv_pair_t outbuff_data,
    output gnn_data_pkg::node_id_t outbuff_node_id,
    output logic                   rs_req,
    output logic                   rs_beat,
    output logic                   rs_sos,
    output logic                   rs_eos,
    output gnn_data_pkg::fv_t      rs_fv_0,
    output gnn_data_pkg::fv_t      rs_fv_1,
    output gnn_data_pkg::node_id_t rs_node_id
);

    // tagged beat storage
    logic                   mem_sos     [edge_bank_pkg::BANK_DEPTH];
    logic                   mem_eos     [edge_bank_pkg::BANK_DEPTH];
    edge_bank_pkg::dest_e   mem_dest    [edge_bank_pkg::BANK_DEPTH];
    gnn_data_pkg::fv_t      mem_fv_0    [edge_bank_pkg::BANK_DEPTH];
    gnn_data_pkg::fv_t      mem_fv_1    [edge_bank_pkg::BANK_DEPTH];
    gnn_data_pkg::node_id_t mem_node_id [edge_bank_pkg::BANK_DEPTH];

    edge_bank_pkg::bank_ptr_t wr_ptr;
    edge_bank_pkg::bank_ptr_t rd_ptr;
    edge_bank_pkg::bank_cnt_t count;
    logic                     head_valid;
    logic                     head_is_sram;
    logic                     wr_en;
    logic                     rd_en;
    // set from rs grant until the eos beat leaves
    logic                     streaming;

    assign head_valid   = (count != '0);
    assign head_is_sram = (mem_dest[rd_ptr] == edge_bank_pkg::DEST_SRAM);
    // a push into a full fifo is lost
    assign wr_en        = push && (count != edge_bank_pkg::BANK_DEPTH);
    assign bank_busy    = (count >= edge_bank_pkg::bank_cnt_t'(edge_bank_pkg::BANK_DEPTH - 1));

    // output sram side shows the head as is
    assign outbuff_req     = head_valid && head_is_sram;
    assign outbuff_sos     = mem_sos[rd_ptr];
    assign outbuff_eos     = mem_eos[rd_ptr];
    assign outbuff_data    = {mem_fv_1[rd_ptr], mem_fv_0[rd_ptr]};
    assign outbuff_node_id = mem_node_id[rd_ptr];

    // ask for the reduction port only at a partial stream start
    assign rs_req = head_valid && !head_is_sram && mem_sos[rd_ptr] && !streaming;
    // stall while reducer is busy or the next beat is not in yet
    assign rs_beat    = streaming && head_valid && rs_available;
    assign rs_sos     = mem_sos[rd_ptr];
    assign rs_eos     = mem_eos[rd_ptr];
    assign rs_fv_0    = mem_fv_0[rd_ptr];
    assign rs_fv_1    = mem_fv_1[rd_ptr];
    assign rs_node_id = mem_node_id[rd_ptr];

    // pop on sram grant or reduction beat
    assign rd_en = (outbuff_req && req_grant) || rs_beat;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            streaming <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + edge_bank_pkg::bank_cnt_t'(wr_en)
                           - edge_bank_pkg::bank_cnt_t'(rd_en);
            if (rs_grant) begin
                streaming <= 1'b1;
            end else if (rs_beat && rs_eos) begin
                streaming <= 1'b0;
            end
        end
    end

    // fifo write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_sos[wr_ptr]     <= tag_sos;
            mem_eos[wr_ptr]     <= tag_eos;
            mem_dest[wr_ptr]    <= tag_dest;
            mem_fv_0[wr_ptr]    <= tag_fv_0;
            mem_fv_1[wr_ptr]    <= tag_fv_1;
            mem_node_id[wr_ptr] <= tag_node_id;
        end
    end

endmodule

/* hdl/edge_bank_pkg.sv */
package edge_bank_pkg;

    // one bank per edge pe
    localparam int NUM_EDGE_PE = 4;

    // one bit per bank
    typedef logic [NUM_EDGE_PE-1:0] bank_mask_t;

    // bank fifo geometry
    localparam int BANK_DEPTH = 8;

    typedef logic [$clog2(BANK_DEPTH)-1:0] bank_ptr_t;
    // one extra bit so a full fifo is countable
    typedef logic [$clog2(BANK_DEPTH):0] bank_cnt_t;

    // where a stream goes, picked at its sos beat
    typedef enum logic {
        DEST_RS   = 1'b0,
        DEST_SRAM = 1'b1
    } dest_e;

    // reduction port ownership
    typedef enum logic {
        LOCK_IDLE    = 1'b0,
        LOCK_BLOCKED = 1'b1
    } lock_e;

endpackage

/* hdl/edge_buffer.sv */
`timescale 1ns/100ps

module edge_buffer (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  edge_bank_pkg::bank_mask_t                             edge_wb_en,
    input  edge_bank_pkg::bank_mask_t                             edge_sos,
    input  edge_bank_pkg::bank_mask_t                             edge_eos,
    input  edge_bank_pkg::bank_mask_t                             edge_done_aggr,
    input  gnn_data_pkg::fv_t      [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_fv_0,
    input  gnn_data_pkg::fv_t      [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_fv_1,
    input  gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_node_id,
    input  edge_bank_pkg::bank_mask_t                             req_grant,
    input  logic                                                  rs_available,
    output edge_bank_pkg::bank_mask_t                             bank_busy,
    output edge_bank_pkg::bank_mask_t                             outbuff_req,
    output edge_bank_pkg::bank_mask_t                             outbuff_sos,
    output edge_bank_pkg::bank_mask_t                             outbuff_eos,
    output gnn_data_pkg::fv_pair_t [edge_bank_pkg::NUM_EDGE_PE-1:0] outbuff_data,
    output gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] outbuff_node_id,
    output logic                                                  rs_beat,
    output logic                                                  rs_sos,
    output logic                                                  rs_eos,
    output gnn_data_pkg::fv_t                                     rs_fv_0,
    output gnn_data_pkg::fv_t                                     rs_fv_1,
    output gnn_data_pkg::node_id_t                                rs_node_id
);

    // decode to bank tags
    edge_bank_pkg::bank_mask_t                               tag_push;
    edge_bank_pkg::bank_mask_t                               tag_sos;
    edge_bank_pkg::bank_mask_t                               tag_eos;
    edge_bank_pkg::dest_e  [edge_bank_pkg::NUM_EDGE_PE-1:0]  tag_dest;
    gnn_data_pkg::fv_t     [edge_bank_pkg::NUM_EDGE_PE-1:0]  tag_fv_0;
    gnn_data_pkg::fv_t     [edge_bank_pkg::NUM_EDGE_PE-1:0]  tag_fv_1;
    gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] tag_node_id;

    // per bank reduction side
    edge_bank_pkg::bank_mask_t                               bank_rs_req;
    edge_bank_pkg::bank_mask_t                               bank_rs_beat;
    edge_bank_pkg::bank_mask_t                               bank_rs_sos;
    edge_bank_pkg::bank_mask_t                               bank_rs_eos;
    gnn_data_pkg::fv_t     [edge_bank_pkg::NUM_EDGE_PE-1:0]  bank_rs_fv_0;
    gnn_data_pkg::fv_t     [edge_bank_pkg::NUM_EDGE_PE-1:0]  bank_rs_fv_1;
    gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] bank_rs_node_id;

    // arbitration and lock
    edge_bank_pkg::bank_mask_t masked_req;
    edge_bank_pkg::bank_mask_t rs_grant;
    edge_bank_pkg::bank_mask_t last_grant;
    edge_bank_pkg::lock_e      lock_state;
    logic                      grant_q;

    for (genvar i = 0; i < edge_bank_pkg::NUM_EDGE_PE; i++) begin : g_bank
        edge_pkt_decode u_decode (
            .clk         (clk),
            .reset       (reset),
            .wb_en       (edge_wb_en[i]),
            .sos         (edge_sos[i]),
            .eos         (edge_eos[i]),
            .done_aggr   (edge_done_aggr[i]),
            .fv_0        (edge_fv_0[i]),
            .fv_1        (edge_fv_1[i]),
            .node_id     (edge_node_id[i]),
            .push        (tag_push[i]),
            .tag_sos     (tag_sos[i]),
            .tag_eos     (tag_eos[i]),
            .tag_dest    (tag_dest[i]),
            .tag_fv_0    (tag_fv_0[i]),
            .tag_fv_1    (tag_fv_1[i]),
            .tag_node_id (tag_node_id[i])
        );

        edge_bank u_bank (
            .clk             (clk),
            .reset           (reset),
            .push            (tag_push[i]),
            .tag_sos         (tag_sos[i]),
            .tag_eos         (tag_eos[i]),
            .tag_dest        (tag_dest[i]),
            .tag_fv_0        (tag_fv_0[i]),
            .tag_fv_1        (tag_fv_1[i]),
            .tag_node_id     (tag_node_id[i]),
            .req_grant       (req_grant[i]),
            .rs_grant        (rs_grant[i]),
            .rs_available    (rs_available),
            .bank_busy       (bank_busy[i]),
            .outbuff_req     (outbuff_req[i]),
            .outbuff_sos     (outbuff_sos[i]),
            .outbuff_eos     (outbuff_eos[i]),
            .outbuff_data    (outbuff_data[i]),
            .outbuff_node_id (outbuff_node_id[i]),
            .rs_req          (bank_rs_req[i]),
            .rs_beat         (bank_rs_beat[i]),
            .rs_sos          (bank_rs_sos[i]),
            .rs_eos          (bank_rs_eos[i]),
            .rs_fv_0         (bank_rs_fv_0[i]),
            .rs_fv_1         (bank_rs_fv_1[i]),
            .rs_node_id      (bank_rs_node_id[i])
        );
    end

    // no new grant while one is settling, the port is owned, or the reducer is busy
    assign masked_req = (grant_q || (lock_state == edge_bank_pkg::LOCK_BLOCKED) || !rs_available)
                      ? '0 : bank_rs_req;

    rr_arbiter u_arbiter (
        .clk    (clk),
        .reset  (reset),
        .reqs   (masked_req),
        .grants (rs_grant)
    );

    // lock fsm
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lock_state <= edge_bank_pkg::LOCK_IDLE;
            last_grant <= '0;
            grant_q    <= 1'b0;
        end else begin
            grant_q <= |rs_grant;
            case (lock_state)
                edge_bank_pkg::LOCK_IDLE: begin
                    if (|rs_grant) begin
                        lock_state <= edge_bank_pkg::LOCK_BLOCKED;
                        last_grant <= rs_grant;
                    end
                end
                default: begin
                    // release as the eos beat passes
                    if (rs_beat && rs_eos) begin
                        lock_state <= edge_bank_pkg::LOCK_IDLE;
                    end
                end
            endcase
        end
    end

    // reduction port mux on the locked bank
    always_comb begin
        rs_beat    = 1'b0;
        rs_sos     = 1'b0;
        rs_eos     = 1'b0;
        rs_fv_0    = '0;
        rs_fv_1    = '0;
        rs_node_id = '0;
        for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
            if ((lock_state == edge_bank_pkg::LOCK_BLOCKED) && last_grant[b]) begin
                rs_beat    = bank_rs_beat[b];
                rs_sos     = bank_rs_sos[b];
                rs_eos     = bank_rs_eos[b];
                rs_fv_0    = bank_rs_fv_0[b];
                rs_fv_1    = bank_rs_fv_1[b];
                rs_node_id = bank_rs_node_id[b];
            end
        end
    end

endmodule

/* hdl/edge_pkt_decode.sv */
`timescale 1ns/100ps

module edge_pkt_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wb_en,
    input  logic                   sos,
    input  logic                   eos,
    input  logic                   done_aggr,
    input  gnn_data_pkg::fv_t      fv_0,
    input  gnn_data_pkg::fv_t      fv_1,
    input  gnn_data_pkg::node_id_t node_id,
    output logic                   push,
    output logic                   tag_sos,
    output logic                   tag_eos,
    output edge_bank_pkg::dest_e   tag_dest,
    output gnn_data_pkg::fv_t      tag_fv_0,
    output gnn_data_pkg::fv_t      tag_fv_1,
    output gnn_data_pkg::node_id_t tag_node_id
);

    // stream open between sos and eos
    logic                 in_stream;
    logic                 accept;
    edge_bank_pkg::dest_e stream_dest;
    edge_bank_pkg::dest_e beat_dest;

    // beats before any sos are dropped here
    assign accept = wb_en && (sos || in_stream);

    // done_aggr only counts on the sos beat
    assign beat_dest = sos ? (done_aggr ? edge_bank_pkg::DEST_SRAM : edge_bank_pkg::DEST_RS)
                           : stream_dest;

    // stream tracking and push strobe
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            in_stream   <= 1'b0;
            stream_dest <= edge_bank_pkg::DEST_RS;
            push        <= 1'b0;
        end else begin
            push <= accept;
            if (accept) begin
                // single beat stream closes at once
                in_stream   <= !eos;
                stream_dest <= beat_dest;
            end
        end
    end

    // tagged beat register
    always_ff @(posedge clk) begin
        if (accept) begin
            tag_sos     <= sos;
            tag_eos     <= eos;
            tag_dest    <= beat_dest;
            tag_fv_0    <= fv_0;
            tag_fv_1    <= fv_1;
            tag_node_id <= node_id;
        end
    end

endmodule

/* hdl/gnn_data_pkg.sv */
package gnn_data_pkg;

    // width of one feature lane
    localparam int FV_SIZE = 16;

    // single feature lane
    typedef logic [FV_SIZE-1:0] fv_t;

    // both lanes side by side for the output sram
    // lane 0 sits in the low half
    typedef logic [2*FV_SIZE-1:0] fv_pair_t;

    // node id space
    localparam int MAX_NODE_ID = 256;

    typedef logic [$clog2(MAX_NODE_ID)-1:0] node_id_t;

endpackage

/* hdl/gnn_edge_top.sv */
`timescale 1ns/100ps

module gnn_edge_top (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  edge_bank_pkg::bank_mask_t                             edge_wb_en,
    input  edge_bank_pkg::bank_mask_t                             edge_sos,
    input  edge_bank_pkg::bank_mask_t                             edge_eos,
    input  edge_bank_pkg::bank_mask_t                             edge_done_aggr,
    input  gnn_data_pkg::fv_t      [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_fv_0,
    input  gnn_data_pkg::fv_t      [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_fv_1,
    input  gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_node_id,
    input  edge_bank_pkg::bank_mask_t                             req_grant,
    output edge_bank_pkg::bank_mask_t                             bank_busy,
    output edge_bank_pkg::bank_mask_t                             outbuff_req,
    output edge_bank_pkg::bank_mask_t                             outbuff_sos,
    output edge_bank_pkg::bank_mask_t                             outbuff_eos,
    output gnn_data_pkg::fv_pair_t [edge_bank_pkg::NUM_EDGE_PE-1:0] outbuff_data,
    output gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] outbuff_node_id,
    output logic                                                  result_valid,
    output gnn_data_pkg::node_id_t                                result_node_id,
    output gnn_data_pkg::fv_t                                     result_sum_0,
    output gnn_data_pkg::fv_t                                     result_sum_1
);

    // reduction port between buffer and reducer
    logic                   rs_available;
    logic                   rs_beat;
    logic                   rs_sos;
    logic                   rs_eos;
    gnn_data_pkg::fv_t      rs_fv_0;
    gnn_data_pkg::fv_t      rs_fv_1;
    gnn_data_pkg::node_id_t rs_node_id;

    edge_buffer u_edge_buffer (
        .clk             (clk),
        .reset           (reset),
        .edge_wb_en      (edge_wb_en),
        .edge_sos        (edge_sos),
        .edge_eos        (edge_eos),
        .edge_done_aggr  (edge_done_aggr),
        .edge_fv_0       (edge_fv_0),
        .edge_fv_1       (edge_fv_1),
        .edge_node_id    (edge_node_id),
        .req_grant       (req_grant),
        .rs_available    (rs_available),
        .bank_busy       (bank_busy),
        .outbuff_req     (outbuff_req),
        .outbuff_sos     (outbuff_sos),
        .outbuff_eos     (outbuff_eos),
        .outbuff_data    (outbuff_data),
        .outbuff_node_id (outbuff_node_id),
        .rs_beat         (rs_beat),
        .rs_sos          (rs_sos),
        .rs_eos          (rs_eos),
        .rs_fv_0         (rs_fv_0),
        .rs_fv_1         (rs_fv_1),
        .rs_node_id      (rs_node_id)
    );

    rs_reduce u_rs_reduce (
        .clk            (clk),
        .reset          (reset),
        .rs_beat        (rs_beat),
        .rs_sos         (rs_sos),
        .rs_eos         (rs_eos),
        .rs_fv_0        (rs_fv_0),
        .rs_fv_1        (rs_fv_1),
        .rs_node_id     (rs_node_id),
        .rs_available   (rs_available),
        .result_valid   (result_valid),
        .result_node_id (result_node_id),
        .result_sum_0   (result_sum_0),
        .result_sum_1   (result_sum_1)
    );

endmodule

/* hdl/rr_arbiter.sv */
`timescale 1ns/100ps

module rr_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  edge_bank_pkg::bank_mask_t reqs,
    output edge_bank_pkg::bank_mask_t grants
);

    // priority pointer kept as a mask of banks at or above it
    edge_bank_pkg::bank_mask_t ptr_mask;
    edge_bank_pkg::bank_mask_t upper_reqs;
    edge_bank_pkg::bank_mask_t pick;

    assign upper_reqs = reqs & ptr_mask;

    // nothing at or above the pointer so wrap to the bottom
    assign pick = (|upper_reqs) ? upper_reqs : reqs;

    // lowest set bit wins
    assign grants = pick & edge_bank_pkg::bank_mask_t'(~pick + 1'b1);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // bank 0 first
            ptr_mask <= '1;
        end else if (|grants) begin
            // move just above the winner
            // top winner clears the mask which acts as a wrap
            ptr_mask <= ~edge_bank_pkg::bank_mask_t'((grants << 1) - 1'b1);
        end
    end

endmodule

/* hdl/rs_reduce.sv */
`timescale 1ns/100ps

module rs_reduce (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rs_beat,
    input  logic                   rs_sos,
    input  logic                   rs_eos,
    input  gnn_data_pkg::fv_t      rs_fv_0,
    input  gnn_data_pkg::fv_t      rs_fv_1,
    input  gnn_data_pkg::node_id_t rs_node_id,
    output logic                   rs_available,
    output logic                   result_valid,
    output gnn_data_pkg::node_id_t result_node_id,
    output gnn_data_pkg::fv_t      result_sum_0,
    output gnn_data_pkg::fv_t      result_sum_1
);

    // running lane sums
    gnn_data_pkg::fv_t acc_0;
    gnn_data_pkg::fv_t acc_1;
    gnn_data_pkg::fv_t sum_0;
    gnn_data_pkg::fv_t sum_1;

    // sos starts fresh
    // sums wrap at 16 bits
    assign sum_0 = rs_sos ? rs_fv_0 : gnn_data_pkg::fv_t'(acc_0 + rs_fv_0);
    assign sum_1 = rs_sos ? rs_fv_1 : gnn_data_pkg::fv_t'(acc_1 + rs_fv_1);

    // busy in the result cycle
    assign rs_available = !result_valid;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= rs_beat && rs_eos;
        end
    end

    // accumulators and result registers
    always_ff @(posedge clk) begin
        if (rs_beat) begin
            acc_0 <= sum_0;
            acc_1 <= sum_1;
        end
        if (rs_beat && rs_eos) begin
            result_sum_0   <= sum_0;
            result_sum_1   <= sum_1;
            result_node_id <= rs_node_id;
        end
    end

endmodule

/* testbench/tb_gnn_edge_top.sv */
`timescale 1ns/100ps

module tb_gnn_edge_top;

    logic                                                    clk = 1'b0;
    logic                                                    reset;
    edge_bank_pkg::bank_mask_t                               edge_wb_en;
    edge_bank_pkg::bank_mask_t                               edge_sos;
    edge_bank_pkg::bank_mask_t                               edge_eos;
    edge_bank_pkg::bank_mask_t                               edge_done_aggr;
    gnn_data_pkg::fv_t      [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_fv_0;
    gnn_data_pkg::fv_t      [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_fv_1;
    gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] edge_node_id;
    edge_bank_pkg::bank_mask_t                               req_grant = '0;
    edge_bank_pkg::bank_mask_t                               bank_busy;
    edge_bank_pkg::bank_mask_t                               outbuff_req;
    edge_bank_pkg::bank_mask_t                               outbuff_sos;
    edge_bank_pkg::bank_mask_t                               outbuff_eos;
    gnn_data_pkg::fv_pair_t [edge_bank_pkg::NUM_EDGE_PE-1:0] outbuff_data;
    gnn_data_pkg::node_id_t [edge_bank_pkg::NUM_EDGE_PE-1:0] outbuff_node_id;
    logic                                                    result_valid;
    gnn_data_pkg::node_id_t                                  result_node_id;
    gnn_data_pkg::fv_t                                       result_sum_0;
    gnn_data_pkg::fv_t                                       result_sum_1;

    // expected sram beats as {sos, eos, node_id, data}
    logic [41:0] sram_q [edge_bank_pkg::NUM_EDGE_PE][$];
    // expected reductions as {node_id, sum_1, sum_0}
    logic [39:0] rs_q [edge_bank_pkg::NUM_EDGE_PE][$];
    int          order_q [$];
    // queue fronts frozen between edges for the assertions
    logic [41:0] exp_head [edge_bank_pkg::NUM_EDGE_PE];
    logic        exp_have [edge_bank_pkg::NUM_EDGE_PE];
    logic [39:0] exp_rs_head [edge_bank_pkg::NUM_EDGE_PE];
    logic        exp_rs_have [edge_bank_pkg::NUM_EDGE_PE];
    logic        exp_order_have;
    int          exp_order_bank;
    logic [39:0] exp_result;
    logic        exp_result_have;

    // one staged stream per bank
    gnn_data_pkg::fv_t      st_fv_0 [edge_bank_pkg::NUM_EDGE_PE][4];
    gnn_data_pkg::fv_t      st_fv_1 [edge_bank_pkg::NUM_EDGE_PE][4];
    gnn_data_pkg::node_id_t st_node [edge_bank_pkg::NUM_EDGE_PE];
    logic                   st_sram [edge_bank_pkg::NUM_EDGE_PE];
    int                     st_len  [edge_bank_pkg::NUM_EDGE_PE];

    logic [31:0]               rand_state;
    logic [31:0]               grant_state = 32'h3b9c;
    edge_bank_pkg::bank_mask_t hold = '0;
    edge_bank_pkg::bank_mask_t held;
    logic                      quiet = 1'b0;
    int                        cycles = 0;
    int                        beats_issued = 0;

    always #2 clk = ~clk;

    gnn_edge_top UUT (.*);

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_random();
        rand_state = lcg_step(rand_state);
        return rand_state;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic void refresh_expect();
        for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
            exp_have[b]    = (sram_q[b].size() != 0);
            exp_rs_have[b] = (rs_q[b].size() != 0);
            exp_head[b]    = '0;
            exp_rs_head[b] = '0;
            if (exp_have[b]) exp_head[b] = sram_q[b][0];
            if (exp_rs_have[b]) exp_rs_head[b] = rs_q[b][0];
        end
        exp_order_have = (order_q.size() != 0);
        exp_order_bank = exp_order_have ? order_q[0] : 0;
    endfunction

    function automatic int pending();
        int n;
        n = order_q.size();
        for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
            n += sram_q[b].size() + rs_q[b].size();
        end
        return n;
    endfunction

    // stage a stream and load its expected beats or sums
    // len 0 picks 1 to 4 beats
    task automatic build_stream(input int b, input logic sram, input int len);
        logic [31:0]       r;
        gnn_data_pkg::fv_t s0;
        gnn_data_pkg::fv_t s1;
        r = next_random();
        st_len[b]  = (len != 0) ? len : 1 + int'(r[29:28]);
        // low two node id bits name the bank
        st_node[b] = {r[21:16], 2'(b)};
        st_sram[b] = sram;
        s0 = '0;
        s1 = '0;
        for (int k = 0; k < st_len[b]; k++) begin
            r = next_random();
            st_fv_0[b][k] = r[31:16];
            r = next_random();
            st_fv_1[b][k] = r[31:16];
            // lane sums wrap at 16 bits
            s0 = s0 + st_fv_0[b][k];
            s1 = s1 + st_fv_1[b][k];
            if (sram) begin
                sram_q[b].push_back({k == 0, k == st_len[b] - 1, st_node[b],
                                     st_fv_1[b][k], st_fv_0[b][k]});
            end
        end
        if (!sram) rs_q[b].push_back({st_node[b], s1, s0});
        refresh_expect();
    endtask

    // one beat per cycle with a pause while the bank is busy
    task automatic drive_stream(input int b);
        for (int k = 0; k < st_len[b]; k++) begin
            while (bank_busy[b]) begin
                edge_wb_en[b] = 1'b0;
                step_cycle();
            end
            edge_wb_en[b]     = 1'b1;
            edge_sos[b]       = (k == 0);
            edge_eos[b]       = (k == st_len[b] - 1);
            edge_done_aggr[b] = st_sram[b];
            edge_fv_0[b]      = st_fv_0[b][k];
            edge_fv_1[b]      = st_fv_1[b][k];
            edge_node_id[b]   = st_node[b];
            beats_issued++;
            step_cycle();
        end
        edge_wb_en[b] = 1'b0;
        edge_sos[b]   = 1'b0;
        edge_eos[b]   = 1'b0;
    endtask

    task automatic drive_all();
        fork
            drive_stream(0);
            drive_stream(1);
            drive_stream(2);
            drive_stream(3);
        join
    endtask

    // grants sampled against hold at the edge and driven just after it
    always @(posedge clk) begin
        held = hold;
        #1;
        for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
            grant_state  = lcg_step(grant_state);
            req_grant[b] = !held[b] && (grant_state[31:30] != 2'b00);
        end
    end

    // retire what the dut hands over at this edge
    always @(posedge clk) begin : monitor
        int idx;
        if (reset) begin
            for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
                if (outbuff_req[b] && req_grant[b] && sram_q[b].size() != 0) begin
                    void'(sram_q[b].pop_front());
                end
            end
            if (result_valid) begin
                idx = int'(result_node_id[1:0]);
                if (rs_q[idx].size() != 0) void'(rs_q[idx].pop_front());
                if (order_q.size() != 0) void'(order_q.pop_front());
            end
            refresh_expect();
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * beats_issued + 200) begin
            stop_on_error($sformatf("timeout after %0d cycles with %0d checks still pending",
                                    cycles, pending()));
        end
    end

    assign exp_result      = exp_rs_head[result_node_id[1:0]];
    assign exp_result_have = exp_rs_have[result_node_id[1:0]];

    assert property (@(posedge clk) quiet |->
        (outbuff_req == '0 && !result_valid && bank_busy == '0))
    else stop_on_error("outputs were not idle right after reset");

    for (genvar b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin : g_sram_chk
        assert property (@(posedge clk) disable iff (!reset) outbuff_req[b] |-> exp_have[b])
        else stop_on_error($sformatf("bank %0d requested a write with no beat expected", b));

        assert property (@(posedge clk) disable iff (!reset) (outbuff_req[b] && exp_have[b]) |->
            ({outbuff_sos[b], outbuff_eos[b], outbuff_node_id[b], outbuff_data[b]} == exp_head[b]))
        else stop_on_error($sformatf("ERR outbuff[%0d] {sos,eos,node_id,data}: got %h expected %h",
            b, $sampled({outbuff_sos[b], outbuff_eos[b], outbuff_node_id[b], outbuff_data[b]}),
            $sampled(exp_head[b])));
    end

    assert property (@(posedge clk) disable iff (!reset) result_valid |-> exp_result_have)
    else stop_on_error("result_valid pulsed with no reduction expected for that node");

    assert property (@(posedge clk) disable iff (!reset) (result_valid && exp_result_have) |->
        ({result_node_id, result_sum_1, result_sum_0} == exp_result))
    else stop_on_error($sformatf("ERR result {node_id,sum_1,sum_0}: got %h expected %h",
        $sampled({result_node_id, result_sum_1, result_sum_0}), $sampled(exp_result)));

    assert property (@(posedge clk) disable iff (!reset) (result_valid && exp_order_have) |->
        (int'(result_node_id[1:0]) == exp_order_bank))
    else stop_on_error($sformatf("ERR result_node_id bank: got %h expected %h",
        $sampled(result_node_id[1:0]), $sampled(exp_order_bank)));

    initial begin : stimulus
        logic [31:0] r;
        reset          = 1'b0;
        edge_wb_en     = '0;
        edge_sos       = '0;
        edge_eos       = '0;
        edge_done_aggr = '0;
        edge_fv_0      = '0;
        edge_fv_1      = '0;
        edge_node_id   = '0;
        rand_state     = 32'h3b9c;
        refresh_expect();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;
        quiet = 1'b1;
        repeat (3) step_cycle();
        quiet = 1'b0;

        // stray beats before any sos would block the bank if kept
        edge_wb_en[3]     = 1'b1;
        edge_done_aggr[3] = 1'b1;
        edge_eos[3]       = 1'b1;
        beats_issued += 2;
        repeat (2) step_cycle();
        edge_wb_en[3] = 1'b0;
        edge_eos[3]   = 1'b0;

        // first requests all at once so the pointer rule sets the order
        for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
            build_stream(b, 1'b0, 0);
            order_q.push_back(b);
        end
        refresh_expect();
        drive_all();
        while (pending() != 0) step_cycle();

        // mixed destinations under random grants
        repeat (8) begin
            for (int b = 0; b < edge_bank_pkg::NUM_EDGE_PE; b++) begin
                r = next_random();
                build_stream(b, r[20], 0);
            end
            drive_all();
        end
        while (pending() != 0) step_cycle();

        // bank 2 starved of grants until it reports busy
        hold[2] = 1'b1;
        fork
            repeat (3) begin
                build_stream(2, 1'b1, 4);
                drive_stream(2);
            end
            begin
                while (!bank_busy[2]) step_cycle();
                repeat (3) step_cycle();
                hold[2] = 1'b0;
            end
        join

        while (pending() != 0) step_cycle();
        repeat (10) step_cycle();
        if (pending() != 0 || outbuff_req != '0) begin
            stop_on_error("expected beats or results were left over at the end");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* verilog.f */
hdl/gnn_data_pkg.sv
hdl/edge_bank_pkg.sv
hdl/edge_pkt_decode.sv
hdl/edge_bank.sv
hdl/rr_arbiter.sv
hdl/edge_buffer.sv
hdl/rs_reduce.sv
hdl/gnn_edge_top.sv
testbench/tb_gnn_edge_top.sv
